// File: design/armPkg.sv
package armPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 4;
    localparam int NumRegs      = 16;
    localparam int InstrWidth   = 32;

    // Instruction field positions
    localparam int CondLsb   = 28;
    localparam int ClassLsb  = 26;
    localparam int ImmBit    = 25;
    localparam int OpcodeLsb = 21;
    localparam int SBit      = 20;
    localparam int RnLsb     = 16;
    localparam int RdLsb     = 12;
    localparam int RmLsb     = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [3:0] OpAnd = 4'b0000;
    localparam logic [3:0] OpEor = 4'b0001;
    localparam logic [3:0] OpSub = 4'b0010;
    localparam logic [3:0] OpRsb = 4'b0011;
    localparam logic [3:0] OpAdd = 4'b0100;
    localparam logic [3:0] OpTst = 4'b1000;
    localparam logic [3:0] OpCmp = 4'b1010;
    localparam logic [3:0] OpOrr = 4'b1100;
    localparam logic [3:0] OpMov = 4'b1101;
    localparam logic [3:0] OpBic = 4'b1110;

    localparam logic [3:0] CondEq = 4'h0;
    localparam logic [3:0] CondNe = 4'h1;
    localparam logic [3:0] CondCs = 4'h2;
    localparam logic [3:0] CondCc = 4'h3;
    localparam logic [3:0] CondMi = 4'h4;
    localparam logic [3:0] CondPl = 4'h5;
    localparam logic [3:0] CondVs = 4'h6;
    localparam logic [3:0] CondVc = 4'h7;
    localparam logic [3:0] CondHi = 4'h8;
    localparam logic [3:0] CondLs = 4'h9;
    localparam logic [3:0] CondGe = 4'hA;
    localparam logic [3:0] CondLt = 4'hB;
    localparam logic [3:0] CondGt = 4'hC;
    localparam logic [3:0] CondLe = 4'hD;
    localparam logic [3:0] CondAl = 4'hE;
    localparam logic [3:0] CondNv = 4'hF;

    localparam logic [1:0] ShLsl = 2'b00;
    localparam logic [1:0] ShLsr = 2'b01;
    localparam logic [1:0] ShAsr = 2'b10;
    localparam logic [1:0] ShRor = 2'b11;

    // Operand field, rotated immediate or shifted register
    typedef union packed {
        struct packed {
            logic [3:0] rotate;
            logic [7:0] value;
        } imm;
        struct packed {
            logic [4:0] shiftAmt;
            logic [1:0] shiftType;
            logic       shiftReg;
            logic [3:0] rm;
        } rs;
    } operand2U;

endpackage

// File: design/instrQueue.sv
`timescale 1ns/10ps

module instrQueue #(
    parameter int QueueDepth = 4
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    input  logic [armPkg::InstrWidth-1:0] instr,
    output logic                          instrCredit,
    output logic                          headValid,
    output logic [armPkg::InstrWidth-1:0] head
);

    localparam int PtrWidth   = $clog2(QueueDepth);
    localparam int CountWidth = $clog2(QueueDepth + 1);

    logic [armPkg::InstrWidth-1:0] mem [QueueDepth];
    logic [PtrWidth-1:0]           wrPtr;
    logic [PtrWidth-1:0]           rdPtr;
    logic [CountWidth-1:0]         count;
    logic                          pop;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        nextPtr = (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head leaves every cycle the queue holds something
    assign pop         = (count != '0);
    assign headValid   = pop;
    assign instrCredit = pop;
    assign head        = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (instrValid) begin
            mem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (instrValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({instrValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/instrDecode.sv
`timescale 1ns/10ps

module instrDecode (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            headValid,
    input  logic [armPkg::InstrWidth-1:0]   head,
    output logic [armPkg::RegAddrWidth-1:0] rdAddrA,
    output logic [armPkg::RegAddrWidth-1:0] rdAddrB,
    input  logic [armPkg::DataWidth-1:0]    rdDataA,
    input  logic [armPkg::DataWidth-1:0]    rdDataB,
    output logic                            dValid,
    output logic [3:0]                      dOpcode,
    output logic [3:0]                      dCond,
    output logic                            dSetFlags,
    output logic                            dWrites,
    output logic                            dIsImm,
    output logic [armPkg::RegAddrWidth-1:0] dRd,
    output logic [armPkg::RegAddrWidth-1:0] dRn,
    output logic [armPkg::RegAddrWidth-1:0] dRm,
    output logic [armPkg::DataWidth-1:0]    dOperandA,
    output logic [armPkg::DataWidth-1:0]    dOperandB,
    output armPkg::operand2U                dOperand2
);

    logic [3:0]       opcode;
    logic [1:0]       instrClass;
    logic             isImm;
    armPkg::operand2U operand2;
    logic             knownOp;
    logic             compareOp;
    logic             decValid;

    assign opcode     = head[armPkg::OpcodeLsb +: 4];
    assign instrClass = head[armPkg::ClassLsb +: 2];
    assign isImm      = head[armPkg::ImmBit];
    assign operand2   = head[$bits(armPkg::operand2U)-1:0];

    always_comb begin
        case (opcode)
            armPkg::OpAnd, armPkg::OpEor, armPkg::OpSub, armPkg::OpRsb,
            armPkg::OpAdd, armPkg::OpTst, armPkg::OpCmp, armPkg::OpOrr,
            armPkg::OpMov, armPkg::OpBic: knownOp = 1'b1;
            default:                      knownOp = 1'b0;
        endcase
    end

    assign compareOp = (opcode == armPkg::OpTst) || (opcode == armPkg::OpCmp);

    // Anything outside the subset becomes a bubble
    assign decValid = headValid && (instrClass == 2'b00) && knownOp
                   && (isImm || !operand2.rs.shiftReg);

    assign rdAddrA = head[armPkg::RnLsb +: armPkg::RegAddrWidth];
    assign rdAddrB = head[armPkg::RmLsb +: armPkg::RegAddrWidth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dValid <= 1'b0;
        end else begin
            dValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        dOpcode   <= opcode;
        dCond     <= head[armPkg::CondLsb +: 4];
        dSetFlags <= head[armPkg::SBit];
        dWrites   <= !compareOp;
        dIsImm    <= isImm;
        dRd       <= head[armPkg::RdLsb +: armPkg::RegAddrWidth];
        dRn       <= rdAddrA;
        dRm       <= rdAddrB;
        dOperandA <= rdDataA;
        dOperandB <= rdDataB;
        dOperand2 <= operand2;
    end

endmodule

// File: design/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [armPkg::RegAddrWidth-1:0] rdAddrA,
    input  logic [armPkg::RegAddrWidth-1:0] rdAddrB,
    output logic [armPkg::DataWidth-1:0]    rdDataA,
    output logic [armPkg::DataWidth-1:0]    rdDataB,
    input  logic                            wbValid,
    input  logic [armPkg::RegAddrWidth-1:0] wbReg,
    input  logic [armPkg::DataWidth-1:0]    wbData
);

    logic [armPkg::DataWidth-1:0] regs [armPkg::NumRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < armPkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbReg] <= wbData;
        end
    end

    // Write-through for the instruction two behind the writer
    assign rdDataA = (wbValid && wbReg == rdAddrA) ? wbData : regs[rdAddrA];
    assign rdDataB = (wbValid && wbReg == rdAddrB) ? wbData : regs[rdAddrB];

endmodule

// File: design/barrelShifter.sv
`timescale 1ns/10ps

module barrelShifter (
    input  armPkg::operand2U             operand2,
    input  logic                         isImm,
    input  logic [armPkg::DataWidth-1:0] regValue,
    input  logic                         carryIn,
    output logic [armPkg::DataWidth-1:0] shiftOut,
    output logic                         shiftCarry
);

    logic [4:0]                     rotAmt;
    logic [4:0]                     amt;
    logic [armPkg::DataWidth-1:0]   immValue;
    logic [2*armPkg::DataWidth-1:0] rotated;
    logic [armPkg::DataWidth:0]     wide;

    assign rotAmt   = {operand2.imm.rotate, 1'b0};
    assign immValue = {24'b0, operand2.imm.value};
    assign amt      = operand2.rs.shiftAmt;

    always_comb begin
        rotated = '0;
        wide    = '0;
        if (isImm) begin
            rotated    = {immValue, immValue} >> rotAmt;
            shiftOut   = rotated[armPkg::DataWidth-1:0];
            shiftCarry = (rotAmt != '0) ? shiftOut[armPkg::DataWidth-1] : carryIn;
        end else begin
            case (operand2.rs.shiftType)
                armPkg::ShLsl: begin
                    wide = {carryIn, regValue};
                    if (amt != '0) begin
                        wide = {1'b0, regValue} << amt;
                    end
                    {shiftCarry, shiftOut} = wide;
                end
                armPkg::ShLsr: begin
                    // Amount zero encodes 32
                    wide = {regValue, 1'b0} >> amt;
                    {shiftOut, shiftCarry} = (amt == '0) ? {32'b0, regValue[31]} : wide;
                end
                armPkg::ShAsr: begin
                    wide = $signed({regValue, 1'b0}) >>> amt;
                    {shiftOut, shiftCarry} = (amt == '0) ? {33{regValue[31]}} : wide;
                end
                default: begin
                    // ROR where amount zero means RRX
                    rotated    = {regValue, regValue} >> amt;
                    shiftOut   = rotated[armPkg::DataWidth-1:0];
                    shiftCarry = shiftOut[armPkg::DataWidth-1];
                    if (amt == '0) begin
                        shiftOut   = {carryIn, regValue[armPkg::DataWidth-1:1]};
                        shiftCarry = regValue[0];
                    end
                end
            endcase
        end
    end

endmodule

// File: design/execUnit.sv
`timescale 1ns/10ps

module execUnit (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            dValid,
    input  logic [3:0]                      dOpcode,
    input  logic [3:0]                      dCond,
    input  logic                            dSetFlags,
    input  logic                            dWrites,
    input  logic                            dIsImm,
    input  logic [armPkg::RegAddrWidth-1:0] dRd,
    input  logic [armPkg::RegAddrWidth-1:0] dRn,
    input  logic [armPkg::RegAddrWidth-1:0] dRm,
    input  logic [armPkg::DataWidth-1:0]    dOperandA,
    input  logic [armPkg::DataWidth-1:0]    dOperandB,
    input  armPkg::operand2U                dOperand2,
    input  logic                            wbValid,
    input  logic [armPkg::RegAddrWidth-1:0] wbReg,
    input  logic [armPkg::DataWidth-1:0]    wbData,
    output logic                            exValid,
    output logic [armPkg::RegAddrWidth-1:0] exRd,
    output logic [armPkg::DataWidth-1:0]    exResult
);

    logic [armPkg::DataWidth-1:0] opA, opB, src2;
    logic [armPkg::DataWidth-1:0] addA, addB;
    logic [armPkg::DataWidth:0]   sum;
    logic addCin, shCarry, isArith, addV, condPass, flagWrite;
    logic flagN, flagZ, flagC, flagV;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from the result register
    ////////////////////////////////////////////////////////////////////////////

    assign opA = (wbValid && wbReg == dRn) ? wbData : dOperandA;
    assign opB = (wbValid && wbReg == dRm) ? wbData : dOperandB;

    barrelShifter barrelShifter_inst (
        .operand2   (dOperand2),
        .isImm      (dIsImm),
        .regValue   (opB),
        .carryIn    (flagC),
        .shiftOut   (src2),
        .shiftCarry (shCarry)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    // One adder where RSB swaps the operands
    always_comb begin
        addA    = opA;
        addB    = src2;
        addCin  = 1'b0;
        isArith = 1'b1;
        case (dOpcode)
            armPkg::OpSub, armPkg::OpCmp: begin
                addB   = ~src2;
                addCin = 1'b1;
            end
            armPkg::OpRsb: begin
                addA   = src2;
                addB   = ~opA;
                addCin = 1'b1;
            end
            armPkg::OpAdd: addCin = 1'b0;
            default:       isArith = 1'b0;
        endcase
        sum  = {1'b0, addA} + {1'b0, addB} + {32'b0, addCin};
        addV = (addA[31] == addB[31]) && (sum[31] != addA[31]);
    end

    always_comb begin
        case (dOpcode)
            armPkg::OpAnd, armPkg::OpTst: exResult = opA & src2;
            armPkg::OpEor:                exResult = opA ^ src2;
            armPkg::OpOrr:                exResult = opA | src2;
            armPkg::OpMov:                exResult = src2;
            armPkg::OpBic:                exResult = opA & ~src2;
            default:                      exResult = sum[armPkg::DataWidth-1:0];
        endcase
    end

    always_comb begin
        case (dCond)
            armPkg::CondEq: condPass = flagZ;
            armPkg::CondNe: condPass = !flagZ;
            armPkg::CondCs: condPass = flagC;
            armPkg::CondCc: condPass = !flagC;
            armPkg::CondMi: condPass = flagN;
            armPkg::CondPl: condPass = !flagN;
            armPkg::CondVs: condPass = flagV;
            armPkg::CondVc: condPass = !flagV;
            armPkg::CondHi: condPass = flagC && !flagZ;
            armPkg::CondLs: condPass = !flagC || flagZ;
            armPkg::CondGe: condPass = (flagN == flagV);
            armPkg::CondLt: condPass = (flagN != flagV);
            armPkg::CondGt: condPass = !flagZ && (flagN == flagV);
            armPkg::CondLe: condPass = flagZ || (flagN != flagV);
            armPkg::CondAl: condPass = 1'b1;
            armPkg::CondNv: condPass = 1'b0;
            default:        condPass = 1'b0;
        endcase
    end

    assign flagWrite = dValid && condPass && (dSetFlags || !dWrites);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {flagN, flagZ, flagC, flagV} <= 4'b0000;
        end else if (flagWrite) begin
            flagN <= exResult[armPkg::DataWidth-1];
            flagZ <= (exResult == '0);
            flagC <= isArith ? sum[armPkg::DataWidth] : shCarry;
            flagV <= isArith ? addV : flagV;
        end
    end

    assign exValid = dValid && condPass && dWrites;
    assign exRd    = dRd;

endmodule

// File: design/resultStage.sv
`timescale 1ns/10ps

module resultStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            exValid,
    input  logic [armPkg::RegAddrWidth-1:0] exRd,
    input  logic [armPkg::DataWidth-1:0]    exResult,
    output logic                            wbValid,
    output logic [armPkg::RegAddrWidth-1:0] wbReg,
    output logic [armPkg::DataWidth-1:0]    wbData
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= exValid;
        end
    end

    // Feeds the register file, forwarding and the trace
    always_ff @(posedge clk) begin
        wbReg  <= exRd;
        wbData <= exResult;
    end

endmodule

// File: design/armCore.sv
`timescale 1ns/10ps

module armCore #(
    parameter int QueueDepth = 4
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            instrValid,
    input  logic [armPkg::InstrWidth-1:0]   instr,
    output logic                            instrCredit,
    output logic                            wbValid,
    output logic [armPkg::RegAddrWidth-1:0] wbReg,
    output logic [armPkg::DataWidth-1:0]    wbData
);

    logic                            headValid;
    logic [armPkg::InstrWidth-1:0]   head;
    logic [armPkg::RegAddrWidth-1:0] rdAddrA, rdAddrB;
    logic [armPkg::DataWidth-1:0]    rdDataA, rdDataB;
    logic                            dValid, dSetFlags, dWrites, dIsImm;
    logic [3:0]                      dOpcode, dCond;
    logic [armPkg::RegAddrWidth-1:0] dRd, dRn, dRm;
    logic [armPkg::DataWidth-1:0]    dOperandA, dOperandB;
    armPkg::operand2U                dOperand2;
    logic                            exValid;
    logic [armPkg::RegAddrWidth-1:0] exRd;
    logic [armPkg::DataWidth-1:0]    exResult;

    instrQueue #(.QueueDepth(QueueDepth)) instrQueue_inst (
        .clk, .rstN, .instrValid, .instr, .instrCredit, .headValid, .head
    );

    instrDecode instrDecode_inst (
        .clk, .rstN, .headValid, .head,
        .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
        .dValid, .dOpcode, .dCond, .dSetFlags, .dWrites, .dIsImm,
        .dRd, .dRn, .dRm, .dOperandA, .dOperandB, .dOperand2
    );

    regFile regFile_inst (
        .clk, .rstN, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
        .wbValid, .wbReg, .wbData
    );

    execUnit execUnit_inst (
        .clk, .rstN,
        .dValid, .dOpcode, .dCond, .dSetFlags, .dWrites, .dIsImm,
        .dRd, .dRn, .dRm, .dOperandA, .dOperandB, .dOperand2,
        .wbValid, .wbReg, .wbData,
        .exValid, .exRd, .exResult
    );

    resultStage resultStage_inst (
        .clk, .rstN, .exValid, .exRd, .exResult, .wbValid, .wbReg, .wbData
    );

endmodule

// File: tests/armCore_sva.sv
`timescale 1ns/10ps

module instrQueueSva #(
    parameter int QueueDepth = 4
) (
    input logic                               clk,
    input logic                               rstN,
    input logic                               instrValid,
    input logic                               instrCredit,
    input logic [$clog2(QueueDepth + 1)-1:0] count
);

    int failCount = 0;
    int pending;

    // Entries held, counted from the handshake alone
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(instrValid) - int'(instrCredit);
        end
    end

    // A push into a full queue is safe only while the head leaves
    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        !(instrValid && pending == QueueDepth && !instrCredit))
        else begin
            failCount++;
            $error("Instruction pushed into a full queue with no dequeue");
        end

    fillMatches: assert property (@(posedge clk) disable iff (!rstN)
        count == pending)
        else begin
            failCount++;
            $error("Queue fill count disagrees with the pushes and credits seen");
        end

    creditNeedsEntry: assert property (@(posedge clk) disable iff (!rstN)
        instrCredit |-> pending != 0)
        else begin
            failCount++;
            $error("Credit returned while the queue was empty");
        end

    creditKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(instrCredit))
        else begin
            failCount++;
            $error("Credit output is unknown after reset");
        end

endmodule

bind instrQueue instrQueueSva #(.QueueDepth(QueueDepth)) instrQueueSva_inst (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instrCredit (instrCredit),
    .count       (count)
);

// File: tests/armCoreTb.sv
`timescale 1ns/10ps

module armCoreTb;

    localparam int QueueDepth = 4;
    localparam int NumRandom  = 400;
    localparam int MaxTraces  = 1024;
    localparam int WaitLimit  = 200;

    localparam logic [3:0] CondPick [12] = '{
        armPkg::CondAl, armPkg::CondAl, armPkg::CondAl, armPkg::CondEq,
        armPkg::CondNe, armPkg::CondCs, armPkg::CondCc, armPkg::CondMi,
        armPkg::CondGe, armPkg::CondLt, armPkg::CondGt, armPkg::CondLe};
    // The last six are outside the subset
    localparam logic [3:0] OpPick [16] = '{
        armPkg::OpAnd, armPkg::OpEor, armPkg::OpSub, armPkg::OpRsb, armPkg::OpAdd,
        armPkg::OpTst, armPkg::OpCmp, armPkg::OpOrr, armPkg::OpMov, armPkg::OpBic,
        4'h5, 4'h6, 4'h7, 4'h9, 4'hB, 4'hF};

    logic        clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        instrCredit;
    logic        wbValid;
    logic [3:0]  wbReg;
    logic [31:0] wbData;

    // Reference model state and expected traces
    logic [31:0] model [16];
    logic        mN, mZ, mC, mV;
    logic [3:0]  expReg [MaxTraces];
    logic [31:0] expData [MaxTraces];
    int          expCount = 0;
    int          traceCount = 0;
    int          credits = QueueDepth;
    int          returned = 0;
    int          sent = 0;
    int          errors = 0;
    int          queueFails;
    bit          timedOut = 1'b0;

    armCore #(.QueueDepth(QueueDepth)) armCore_inst (
        .clk, .rstN, .instrValid, .instr, .instrCredit, .wbValid, .wbReg, .wbData
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (rstN) begin
            credits  <= credits + int'(instrCredit) - int'(instrValid);
            returned <= returned + int'(instrCredit);
        end
        if (wbValid) begin
            traceCount <= traceCount + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    traceWanted: assert property (@(negedge clk) disable iff (!rstN)
        wbValid |-> traceCount < expCount)
        else begin
            errors++;
            $display("Trace seen with no expected register write left");
        end

    regMatch: assert property (@(negedge clk) disable iff (!rstN)
        wbValid && traceCount < expCount |-> wbReg == expReg[traceCount])
        else begin
            errors++;
            $display("ERROR wbReg expected %h got %h", expReg[traceCount], wbReg);
        end

    dataMatch: assert property (@(negedge clk) disable iff (!rstN)
        wbValid && traceCount < expCount |-> wbData == expData[traceCount])
        else begin
            errors++;
            $display("ERROR wbData expected %h got %h", expData[traceCount], wbData);
        end

    creditRange: assert property (@(negedge clk) credits >= 0 && credits <= QueueDepth)
        else begin
            errors++;
            $display("Producer credit count %0d left the range 0 to %0d", credits, QueueDepth);
        end

    // Quiet in reset and in the first cycle after it
    resetWb: assert property (@(negedge clk) !rstN || !$past(rstN) |-> !wbValid)
        else begin
            errors++;
            $display("ERROR wbValid expected %h got %h", 1'b0, wbValid);
        end

    resetCredit: assert property (@(negedge clk) !rstN || !$past(rstN) |-> !instrCredit)
        else begin
            errors++;
            $display("ERROR instrCredit expected %h got %h", 1'b0, instrCredit);
        end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic bit condHolds(input logic [3:0] cond);
        case (cond)
            armPkg::CondEq: return mZ;
            armPkg::CondNe: return !mZ;
            armPkg::CondCs: return mC;
            armPkg::CondCc: return !mC;
            armPkg::CondMi: return mN;
            armPkg::CondGe: return mN == mV;
            armPkg::CondLt: return mN != mV;
            armPkg::CondGt: return !mZ && (mN == mV);
            armPkg::CondLe: return mZ || (mN != mV);
            armPkg::CondAl: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    task automatic operandTwo(input logic [31:0] w, output logic [31:0] val, output logic cy);
        logic [31:0] v;
        int          amt;
        v   = model[w[3:0]];
        amt = int'(w[11:7]);
        cy  = mC;
        if (w[25]) begin
            amt = 2 * int'(w[11:8]);
            val = {24'b0, w[7:0]};
            val = (val >> amt) | (val << (32 - amt));
            if (amt != 0) begin
                cy = val[31];
            end
        end else begin
            case (w[6:5])
                2'b00: begin
                    val = v << amt;
                    if (amt != 0) begin
                        cy = v[32 - amt];
                    end
                end
                2'b01: begin
                    if (amt == 0) begin
                        amt = 32;
                    end
                    val = v >> amt;
                    cy  = v[amt - 1];
                end
                2'b10: begin
                    if (amt == 0) begin
                        amt = 32;
                    end
                    val = $signed(v) >>> amt;
                    cy  = v[amt - 1];
                end
                default: begin
                    if (amt == 0) begin
                        // RRX
                        val = {mC, v[31:1]};
                        cy  = v[0];
                    end else begin
                        val = (v >> amt) | (v << (32 - amt));
                        cy  = val[31];
                    end
                end
            endcase
        end
    endtask

    task automatic modelStep(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [3:0]  op;
        logic        cy;
        logic        ov;
        op = w[24:21];
        if (w[27:26] != 2'b00 || (!w[25] && w[4])) begin
            return;
        end
        if (!(op inside {armPkg::OpAnd, armPkg::OpEor, armPkg::OpSub, armPkg::OpRsb,
                         armPkg::OpAdd, armPkg::OpTst, armPkg::OpCmp, armPkg::OpOrr,
                         armPkg::OpMov, armPkg::OpBic}) || !condHolds(w[31:28])) begin
            return;
        end
        a = model[w[19:16]];
        operandTwo(w, b, cy);
        ov = mV;
        case (op)
            armPkg::OpSub, armPkg::OpCmp: begin
                r  = a - b;
                cy = a >= b;
                ov = (a[31] != b[31]) && (r[31] != a[31]);
            end
            armPkg::OpRsb: begin
                r  = b - a;
                cy = b >= a;
                ov = (a[31] != b[31]) && (r[31] != b[31]);
            end
            armPkg::OpAdd: begin
                {cy, r} = {1'b0, a} + {1'b0, b};
                ov      = (a[31] == b[31]) && (r[31] != a[31]);
            end
            armPkg::OpEor: r = a ^ b;
            armPkg::OpOrr: r = a | b;
            armPkg::OpMov: r = b;
            armPkg::OpBic: r = a & ~b;
            default:       r = a & b;
        endcase
        if (w[20] || op == armPkg::OpTst || op == armPkg::OpCmp) begin
            mN = r[31];
            mZ = (r == '0);
            mC = cy;
            mV = ov;
        end
        if (op != armPkg::OpTst && op != armPkg::OpCmp) begin
            model[w[15:12]]   = r;
            expReg[expCount]  = w[15:12];
            expData[expCount] = r;
            expCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Producer
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        w        = $urandom();
        w[31:28] = CondPick[$urandom_range(0, 11)];
        w[27:26] = ($urandom_range(0, 49) == 0) ? 2'($urandom_range(1, 3)) : 2'b00;
        w[24:21] = ($urandom_range(0, 11) == 0) ? OpPick[$urandom_range(10, 15)]
                                                : OpPick[$urandom_range(0, 9)];
        // Few registers so dependencies come close together
        w[19:16] = 4'($urandom_range(0, 3));
        w[15:12] = 4'($urandom_range(0, 3));
        if (!w[25]) begin
            w[3:0] = 4'($urandom_range(0, 3));
            w[4]   = ($urandom_range(0, 19) == 0);
            if ($urandom_range(0, 3) == 0) begin
                w[11:7] = 5'b0;
            end
        end
        return w;
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic sendWord(input logic [31:0] word);
        int waited;
        waited = 0;
        while (credits == 0 && waited < WaitLimit) begin
            idleCycles(1);
            waited++;
        end
        if (credits == 0) begin
            timedOut = 1'b1;
            $display("Timed out waiting for an instruction credit");
        end else begin
            instr      = word;
            instrValid = 1'b1;
            modelStep(word);
            sent++;
            idleCycles(1);
            instrValid = 1'b0;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(76));
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        {mN, mZ, mC, mV} = 4'b0000;
        repeat (16) @(posedge clk);
        #0.5;
        rstN = 1'b1;

        // Rotated immediates through MOV then ORR
        for (int i = 0; i < 24 && !timedOut; i++) begin
            sendWord({armPkg::CondAl, 3'b001, (i < 16) ? armPkg::OpMov : armPkg::OpOrr,
                      1'b0, 4'(i % 4), 4'((i + 1) % 4), 4'(i % 16), 8'($urandom())});
        end
        for (int i = 0; i < NumRandom && !timedOut; i++) begin
            sendWord(randomWord());
            if ($urandom_range(0, 4) == 0) begin
                idleCycles($urandom_range(1, 3));
            end
        end

        waited = 0;
        while (!timedOut && credits != QueueDepth && waited < WaitLimit) begin
            idleCycles(1);
            waited++;
        end
        if (!timedOut && credits != QueueDepth) begin
            timedOut = 1'b1;
            $display("Timed out waiting for the queue to drain");
        end
        if (!timedOut) begin
            // Last dequeue reaches the trace two cycles later
            idleCycles(3);
            assert (returned == sent)
            else begin
                errors++;
                $display("ERROR instrCredit returned %h sent %h", returned, sent);
            end
            assert (traceCount == expCount)
            else begin
                errors++;
                $display("ERROR wbValid traces %h expected %h", traceCount, expCount);
            end
        end

        queueFails = armCore_inst.instrQueue_inst.instrQueueSva_inst.failCount;
        $display("Errors %0d, queue assertion failures %0d, timeouts %0d",
                 errors, queueFails, int'(timedOut));
        if (errors == 0 && queueFails == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: flist.f
design/armPkg.sv
design/instrQueue.sv
design/instrDecode.sv
design/regFile.sv
design/barrelShifter.sv
design/execUnit.sv
design/resultStage.sv
design/armCore.sv
tests/armCore_sva.sv
tests/armCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= armCoreTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
